//--- clk_rst_gen.f
clk_rst_pkg.sv
apb_pkg.sv
clk_int_div.sv
rst_sync.sv
clk_rst_regs.sv
clk_rst_gen.sv
tb_clk_gen.sv
tb_clk_rst_gen.sv

//--- Makefile
# Verilator build and run of the clock and reset generator testbench

VERILATOR ?= verilator
TOP       ?= tb_clk_rst_gen
FILELIST  ?= clk_rst_gen.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the testbench printed the pass message on a line of its own
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_clk_rst_gen.sv
// Directed testbench for the clock and reset generator.
// Drives APB, the debug pin and test mode on falling clock edges and checks
// divider periods, gating, reset release timing and APB error responses.

`timescale 1ns/10ps
`default_nettype none

module tb_clk_rst_gen
  import clk_rst_pkg::*;
  import apb_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int MAX_DIV    = 40;          // Largest random divide value
  localparam int MAX_PERIOD = 2 * MAX_DIV;
  // All tests together take about 50 periods of the slowest clock
  // and the budget allows five times that
  localparam int WATCHDOG_CYCLES = 250 * MAX_PERIOD;

  logic             clk;
  logic             por_n;
  logic             rst_n;
  logic             rst_req;               // Extra chip reset pulse from the tests
  logic             test_mode;
  logic             rst_dm;
  apb_req_t         apb_req;
  apb_rsp_t         apb_rsp;
  logic             clk_per;
  logic             clk_cluster;
  logic             clk_aux;
  rst_vec_t         rst_vec;
  int               seed = 87183;
  logic [DIV_W-1:0] exp_div [NUM_DIV];     // Divide values the registers should hold

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(5)) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( por_n )
  );

  assign rst_n = por_n && !rst_req;

  clk_rst_gen UUT (
    .clk           ( clk         ),
    .rst_n_i       ( rst_n       ),
    .test_mode_i   ( test_mode   ),
    .rst_dm_i      ( rst_dm      ),
    .apb_i         ( apb_req     ),
    .apb_o         ( apb_rsp     ),
    .clk_per_o     ( clk_per     ),
    .clk_cluster_o ( clk_cluster ),
    .clk_aux_o     ( clk_aux     ),
    .rst_vec_o     ( rst_vec     )
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  function automatic logic div_clk(input int sel);
    case (sel)
      0:       return clk_per;
      1:       return clk_cluster;
      default: return clk_aux;
    endcase
  endfunction

  function automatic logic [APB_AW-1:0] div_addr(input int sel);
    case (sel)
      0:       return REG_DIV_PER;
      1:       return REG_DIV_CLUSTER;
      default: return REG_DIV_AUX;
    endcase
  endfunction

  // High for D cycles and low for D cycles with zero counting as one
  function automatic int period_of(input logic [DIV_W-1:0] value);
    return (value == '0) ? 2 : 2 * int'(value);
  endfunction

  // Setup phase followed by an access phase sampled a quarter period in
  task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(CLK_PERIOD / 4);
    check(apb_rsp.pready, 1'b1, "pready in access phase");
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           output logic err);
    logic [APB_DW-1:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // Counts cycles between two successive rising edges on falling clk edges
  task automatic measure_period(input int sel, output int cycles);
    logic prev;
    logic cur;
    int   n;
    int   first;
    prev   = div_clk(sel);
    n      = 0;
    first  = -1;
    cycles = 0;
    while (cycles == 0) begin
      @(negedge clk);
      n++;
      cur = div_clk(sel);
      if (cur && !prev) begin
        if (first < 0) begin
          first = n;
        end else begin
          cycles = n - first;
        end
      end
      prev = cur;
      if (n > 3 * MAX_PERIOD) begin
        abort_run($sformatf("Divided clock %0d shows no two rising edges", sel));
      end
    end
  endtask

  task automatic wait_pending_clear(input int sel);
    logic [31:0] status;
    logic        err;
    int          polls;
    polls  = 0;
    status = '1;
    while (status[sel]) begin
      apb_read(REG_STATUS, status, err);
      polls++;
      if (polls > MAX_PERIOD) begin
        abort_run($sformatf("Divider %0d still pending after %0d reads", sel, polls));
      end
    end
  endtask

  // Counts falling edges until the debug-resettable domains come out of reset
  task automatic check_release(input string src);
    int rise [3];
    check(rst_vec, 4'b0001, {src, ", domains held before release"});
    for (int b = 0; b < 3; b++) begin
      rise[b] = 0;
    end
    for (int n = 1; n <= 2 * RST_SYNC_STAGES + 2; n++) begin
      @(negedge clk);
      check(rst_vec.glob, 1'b1, {src, ", global reset must stay released"});
      if (rst_vec.soc && rise[0] == 0) rise[0] = n;
      if (rst_vec.per && rise[1] == 0) rise[1] = n;
      if (rst_vec.cluster && rise[2] == 0) rise[2] = n;
    end
    check(rise[0], RST_SYNC_STAGES, {src, ", soc release delay"});
    check(rise[1], RST_SYNC_STAGES, {src, ", per release delay"});
    check(rise[2], RST_SYNC_STAGES, {src, ", cluster release delay"});
  endtask

  task automatic reset_defaults();
    logic [31:0] data;
    logic        err;
    logic [3:0]  rv;
    int          rise [4];
    int          cycles;
    @(posedge rst_n);
    check(rst_vec, 4'h0, "domain resets during chip reset");
    check({clk_aux, clk_cluster, clk_per}, 3'b000, "divided clocks during chip reset");
    for (int b = 0; b < 4; b++) begin
      rise[b] = 0;
    end
    for (int n = 1; n <= 2 * RST_SYNC_STAGES + 2; n++) begin
      @(negedge clk);
      rv = rst_vec;
      for (int b = 0; b < 4; b++) begin
        if (rv[b] && rise[b] == 0) rise[b] = n;
      end
    end
    for (int b = 0; b < 4; b++) begin
      check(rise[b] >= RST_SYNC_STAGES, 1'b1, $sformatf("reset %0d release too early", b));
    end
    apb_read(REG_ID, data, err);
    check(data, ID_VALUE, "ID value");
    check(err, 1'b0, "pslverr on ID read");
    for (int i = 0; i < NUM_DIV; i++) begin
      apb_read(div_addr(i), data, err);
      check(data, 32'(DIV_DEFAULT), $sformatf("DIV register %0d after reset", i));
      measure_period(i, cycles);
      check(cycles, period_of(DIV_DEFAULT), $sformatf("divider %0d default period", i));
    end
  endtask

  task automatic divide_values();
    logic [31:0] data;
    logic        err;
    int          cycles;
    for (int i = 0; i < NUM_DIV; i++) begin
      exp_div[i] = DIV_W'(1 + ({$random(seed)} % MAX_DIV));
      apb_write(div_addr(i), 32'(exp_div[i]), err);
      check(err, 1'b0, $sformatf("pslverr on DIV register %0d write", i));
      wait_pending_clear(i);
      apb_read(div_addr(i), data, err);
      check(data, 32'(exp_div[i]), $sformatf("DIV register %0d readback", i));
      measure_period(i, cycles);
      check(cycles, period_of(exp_div[i]),
            $sformatf("divider %0d period for value %0d", i, exp_div[i]));
    end
    exp_div[DIV_AUX] = '0;                 // Zero acts as one
    apb_write(REG_DIV_AUX, 32'h0, err);
    check(err, 1'b0, "pslverr on aux DIV register write of 0");
    wait_pending_clear(DIV_AUX);
    measure_period(DIV_AUX, cycles);
    check(cycles, 2, "aux period for value 0");
  endtask

  task automatic clock_gating();
    logic       err;
    logic [2:0] prev;
    logic [2:0] cur;
    int         rises [NUM_DIV];
    int         window;
    int         n;
    int         cycles;
    window = 0;
    for (int i = 0; i < NUM_DIV; i++) begin
      if (period_of(exp_div[i]) > window) window = period_of(exp_div[i]);
    end
    window = 3 * window;                   // Three periods of the slowest clock
    for (int sel = 0; sel < NUM_DIV; sel++) begin
      apb_write(REG_CTRL, 32'(1 << sel), err);
      check(err, 1'b0, "pslverr on CTRL write");
      n = 0;
      while (div_clk(sel)) begin           // Current high phase runs to its end
        @(negedge clk);
        n++;
        if (n > MAX_PERIOD) begin
          abort_run($sformatf("Gated divider %0d never went low", sel));
        end
      end
      prev = {clk_aux, clk_cluster, clk_per};
      for (int j = 0; j < NUM_DIV; j++) begin
        rises[j] = 0;
      end
      repeat (window) begin
        @(negedge clk);
        cur = {clk_aux, clk_cluster, clk_per};
        check(cur[sel], 1'b0, $sformatf("gated divider %0d output", sel));
        for (int j = 0; j < NUM_DIV; j++) begin
          if (cur[j] && !prev[j]) rises[j]++;
        end
        prev = cur;
      end
      for (int j = 0; j < NUM_DIV; j++) begin
        if (j != sel) begin
          check(rises[j] > 0, 1'b1, $sformatf("divider %0d toggling while %0d gated", j, sel));
        end
      end
      apb_write(REG_CTRL, 32'h0, err);
      measure_period(sel, cycles);
      check(cycles, period_of(exp_div[sel]), $sformatf("divider %0d period after ungate", sel));
    end
  endtask

  task automatic debug_reset();
    logic [31:0] data;
    logic        err;
    apb_write(REG_CTRL, 32'h100, err);
    check(err, 1'b0, "pslverr on CTRL write");
    @(negedge clk);
    check(rst_vec, 4'b0001, "reset outputs under debug register request");
    apb_read(REG_STATUS, data, err);
    check(data[11:8], 4'b0001, "STATUS resets under debug register request");
    apb_write(REG_CTRL, 32'h0, err);
    check_release("debug register bit");
    @(negedge clk);
    rst_dm = 1'b1;
    @(negedge clk);
    check(rst_vec, 4'b0001, "reset outputs under debug pin");
    apb_read(REG_STATUS, data, err);
    check(data[11:8], 4'b0001, "STATUS resets under debug pin");
    @(negedge clk);
    rst_dm = 1'b0;
    check_release("debug pin");
  endtask

  task automatic apb_errors();
    logic [31:0] data;
    logic        err;
    apb_read(8'h20, data, err);
    check(err, 1'b1, "pslverr on read of unmapped 0x20");
    apb_write(8'h20, 32'hFFFF_FFFF, err);
    check(err, 1'b1, "pslverr on write to unmapped 0x20");
    apb_write(REG_STATUS, 32'hFFFF_FFFF, err);
    check(err, 1'b1, "pslverr on write to STATUS");
    apb_write(REG_ID, 32'h0, err);
    check(err, 1'b1, "pslverr on write to ID");
    apb_read(REG_CTRL, data, err);
    check(data, 32'h0, "CTRL after rejected writes");
    check(err, 1'b0, "pslverr on CTRL read");
    for (int i = 0; i < NUM_DIV; i++) begin
      apb_read(div_addr(i), data, err);
      check(data, 32'(exp_div[i]), $sformatf("DIV register %0d after rejected writes", i));
    end
    apb_read(REG_ID, data, err);
    check(data, ID_VALUE, "ID after rejected write");
    apb_read(REG_STATUS, data, err);
    check(data, 32'h0000_0F00, "STATUS after rejected writes");
  endtask

  task automatic test_mode_bypass();
    logic [31:0] data;
    logic        err;
    int          n;
    @(negedge clk);
    test_mode = 1'b1;
    @(negedge clk);
    check(rst_vec, 4'hF, "test mode, chip reset released");
    rst_req = 1'b1;
    #(CLK_PERIOD / 4);
    check(rst_vec, 4'h0, "test mode, chip reset asserted");   // No clk edge yet
    @(negedge clk);
    rst_req = 1'b0;
    #(CLK_PERIOD / 4);
    check(rst_vec, 4'hF, "test mode, right after chip reset release");  // Sync path still low
    @(negedge clk);
    rst_dm = 1'b1;
    @(negedge clk);
    check(rst_vec, 4'hF, "test mode ignores the debug pin");
    rst_dm    = 1'b0;
    test_mode = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 4 * RST_SYNC_STAGES) begin
        abort_run("Domain resets stayed low after leaving test mode");
      end
    end while (rst_vec != 4'hF);
    // The chip reset pulse brought the divide values back to default
    for (int i = 0; i < NUM_DIV; i++) begin
      apb_read(div_addr(i), data, err);
      check(data, 32'(DIV_DEFAULT), $sformatf("DIV register %0d after chip reset", i));
    end
  endtask

  initial begin
    apb_req   = '0;
    test_mode = 1'b0;
    rst_dm    = 1'b0;
    rst_req   = 1'b0;
    for (int i = 0; i < NUM_DIV; i++) begin
      exp_div[i] = DIV_DEFAULT;
    end
    reset_defaults();
    divide_values();
    clock_gating();
    debug_reset();
    apb_errors();
    test_mode_bypass();
    $display("Verification passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout, tests still running after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Clock and power-on reset source for the testbench.
// Free-running clock, reset held low for the first cycles and released
// on a falling edge so that it never meets a sampling edge.

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = !clk_o;

endmodule

`default_nettype wire

//--- clk_rst_gen.sv
// Clock and reset generator top level.
// One APB register block steers three divided clocks and four domain
// resets. Only the global reset ignores the debug reset request.

`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen
  import clk_rst_pkg::*;
  import apb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     test_mode_i,
  input  logic     rst_dm_i,        // Debug reset request pin
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o,
  output logic     clk_per_o,
  output logic     clk_cluster_o,
  output logic     clk_aux_o,
  output rst_vec_t rst_vec_o
);

  div_cfg_t  [NUM_DIV-1:0] div_cfg;
  div_stat_t [NUM_DIV-1:0] div_stat;
  logic      [NUM_DIV-1:0] gate;
  logic      [NUM_DIV-1:0] div_clk;
  logic                    dm_req_reg;
  logic                    dm_req;
  logic                    chip_req;
  rst_vec_t                rst_vec;

  assign chip_req = !rst_n_i;
  assign dm_req   = dm_req_reg || rst_dm_i;   // Register bit or pin

  clk_rst_regs i_regs (
    .clk        ( clk         ),
    .rst_n_i    ( rst_n_i     ),
    .apb_i      ( apb_i       ),
    .apb_o      ( apb_o       ),
    .div_cfg_o  ( div_cfg     ),
    .gate_o     ( gate        ),
    .dm_req_o   ( dm_req_reg  ),
    .div_stat_i ( div_stat    ),
    .rst_vec_i  ( rst_vec     )
  );

  for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
    clk_int_div i_div (
      .clk     ( clk         ),
      .rst_n_i ( rst_n_i     ),
      .cfg_i   ( div_cfg[i]  ),
      .gate_i  ( gate[i]     ),
      .clk_o   ( div_clk[i]  ),
      .stat_o  ( div_stat[i] )
    );
  end

  assign clk_per_o     = div_clk[DIV_PER];
  assign clk_cluster_o = div_clk[DIV_CLUSTER];
  assign clk_aux_o     = div_clk[DIV_AUX];

  rst_sync i_rst_glob (
    .clk (clk), .rst_n_i (rst_n_i), .rst_req_i (chip_req),
    .test_mode_i (test_mode_i), .rst_n_o (rst_vec.glob)
  );

  rst_sync i_rst_soc (
    .clk (clk), .rst_n_i (rst_n_i), .rst_req_i (chip_req || dm_req),
    .test_mode_i (test_mode_i), .rst_n_o (rst_vec.soc)
  );

  rst_sync i_rst_per (
    .clk (clk), .rst_n_i (rst_n_i), .rst_req_i (chip_req || dm_req),
    .test_mode_i (test_mode_i), .rst_n_o (rst_vec.per)
  );

  rst_sync i_rst_cluster (
    .clk (clk), .rst_n_i (rst_n_i), .rst_req_i (chip_req || dm_req),
    .test_mode_i (test_mode_i), .rst_n_o (rst_vec.cluster)
  );

  assign rst_vec_o = rst_vec;

endmodule

`default_nettype wire

//--- clk_rst_regs.sv
// APB register block of the clock and reset generator.
// Holds gate enables, the debug reset request and the three divide values,
// pulses a divider's update strobe on each write to its register and
// reads back divider and reset status. No wait states.

`timescale 1ns/10ps
`default_nettype none

module clk_rst_regs
  import clk_rst_pkg::*;
  import apb_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  apb_req_t                apb_i,
  output apb_rsp_t                apb_o,
  output div_cfg_t  [NUM_DIV-1:0] div_cfg_o,
  output logic      [NUM_DIV-1:0] gate_o,
  output logic                    dm_req_o,
  input  div_stat_t [NUM_DIV-1:0] div_stat_i,
  input  rst_vec_t                rst_vec_i
);

  logic [NUM_DIV-1:0] gate_q;
  logic               dm_q;
  logic [DIV_W-1:0]   div_q [NUM_DIV];
  logic [NUM_DIV-1:0] upd_q;     // Update strobes one cycle after the write

  logic               access;
  logic               mapped;
  logic               read_only;
  logic               div_hit;
  div_idx_e           div_sel;
  logic               bad;
  logic               wr_ok;
  logic [APB_DW-1:0]  rdata;
  logic [APB_DW-1:0]  ctrl_word;
  logic [APB_DW-1:0]  status_word;

  assign access = apb_i.psel && apb_i.penable;

  always_comb begin
    ctrl_word                = '0;
    ctrl_word[NUM_DIV-1:0]   = gate_q;
    ctrl_word[8]             = dm_q;
  end

  always_comb begin
    status_word = '0;
    for (int i = 0; i < NUM_DIV; i++) begin
      status_word[i] = div_stat_i[i].pending;
    end
    status_word[11:8] = rst_vec_i;   // Bit 8 is the global reset
  end

  // Address decode and read mux
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    div_hit   = 1'b0;
    div_sel   = DIV_PER;
    rdata     = '0;
    case (apb_i.paddr)
      REG_CTRL:        rdata = ctrl_word;
      REG_DIV_PER: begin
        div_hit = 1'b1;
        div_sel = DIV_PER;
      end
      REG_DIV_CLUSTER: begin
        div_hit = 1'b1;
        div_sel = DIV_CLUSTER;
      end
      REG_DIV_AUX: begin
        div_hit = 1'b1;
        div_sel = DIV_AUX;
      end
      REG_STATUS: begin
        read_only = 1'b1;
        rdata     = status_word;
      end
      REG_ID: begin
        read_only = 1'b1;
        rdata     = ID_VALUE;
      end
      default:         mapped = 1'b0;
    endcase
    if (div_hit) begin
      rdata = APB_DW'(div_q[div_sel]);
    end
  end

  assign bad   = !mapped || (apb_i.pwrite && read_only);
  assign wr_ok = access && apb_i.pwrite && !bad;

  assign apb_o = '{
    prdata:  access ? rdata : '0,
    pready:  1'b1,                 // Never stalls
    pslverr: access && bad
  };

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      gate_q <= '0;
      dm_q   <= 1'b0;
      upd_q  <= '0;
      for (int i = 0; i < NUM_DIV; i++) begin
        div_q[i] <= DIV_DEFAULT;
      end
    end else begin
      upd_q <= '0;
      if (wr_ok && (apb_i.paddr == REG_CTRL)) begin
        gate_q <= apb_i.pwdata[NUM_DIV-1:0];
        dm_q   <= apb_i.pwdata[8];
      end
      if (wr_ok && div_hit) begin
        div_q[div_sel] <= apb_i.pwdata[DIV_W-1:0];
        upd_q[div_sel] <= 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_DIV; i++) begin
      div_cfg_o[i] = '{value: div_q[i], update: upd_q[i]};
    end
  end

  assign gate_o   = gate_q;
  assign dm_req_o = dm_q;

  // An access phase is always preceded by a selected setup phase
  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(apb_i.penable) |-> apb_i.psel);

endmodule

`default_nettype wire

//--- rst_sync.sv
// Reset synchronizer for one reset domain, running on clk.
// A request pulls the output low on the next edge and release is delayed
// by RST_SYNC_STAGES cycles. Test mode passes rst_n_i straight through.

`timescale 1ns/10ps
`default_nettype none

module rst_sync
  import clk_rst_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic rst_req_i,     // Active high reset request
  input  logic test_mode_i,
  output logic rst_n_o
);

  logic [RST_SYNC_STAGES-1:0] sync_q;

  // Ones shift in from bit 0 once the request is gone
  always_ff @(posedge clk) begin
    if (!rst_n_i || rst_req_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n_o = test_mode_i ? rst_n_i : sync_q[RST_SYNC_STAGES-1];

  // Functional mode holds the domain in reset right after any request
  a_req_low: assert property (@(posedge clk) disable iff (test_mode_i)
    rst_req_i |=> !rst_n_o);

endmodule

`default_nettype wire

//--- clk_int_div.sv
// Integer clock divider running in the clk domain with a registered output.
// With value D the output is high for D and low for D cycles, and 0 acts as 1.
// New values wait in a one-entry buffer and are taken where a low phase begins.
// The gate only acts in the low phase, so high pulses are never cut short.

`timescale 1ns/10ps
`default_nettype none

module clk_int_div
  import clk_rst_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  div_cfg_t  cfg_i,
  input  logic      gate_i,
  output logic      clk_o,
  output div_stat_t stat_o
);

  logic [DIV_W-1:0] div_act_q;    // Value of the running period
  logic [DIV_W-1:0] buf_q;
  logic             pending_q;
  logic [DIV_W-1:0] cnt_q;        // Cycles spent in the current phase
  logic             clk_q;
  logic [DIV_W-1:0] new_div;
  logic             phase_end;
  logic             hold;
  logic             swap;
  logic [DIV_W-1:0] hi_run_q;
  logic [DIV_W+1:0] pend_age_q;

  assign new_div   = (cfg_i.value == '0) ? DIV_W'(1) : cfg_i.value;
  assign phase_end = (cnt_q == div_act_q - DIV_W'(1));
  assign hold      = !clk_q && gate_i;   // Gated and parked in the low phase

  // A held output counts as a fresh low phase, so buffered values still land
  assign swap = pending_q && (hold || (clk_q && phase_end));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      clk_q     <= 1'b0;
      div_act_q <= DIV_DEFAULT;
    end else begin
      if (hold) begin
        cnt_q <= '0;                     // Rise comes D cycles after ungating
      end else if (phase_end) begin
        cnt_q <= '0;
        clk_q <= !clk_q;
      end else begin
        cnt_q <= cnt_q + DIV_W'(1);
      end
      if (swap) begin
        div_act_q <= buf_q;
      end
    end
  end

  // Lossy buffer where a newer write replaces the older one
  always_ff @(posedge clk) begin
    if (cfg_i.update) begin
      buf_q <= new_div;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else if (cfg_i.update) begin
      pending_q <= 1'b1;                 // Strobe wins over a same-cycle swap
    end else if (swap) begin
      pending_q <= 1'b0;
    end
  end

  assign clk_o  = clk_q;
  assign stat_o = '{pending: pending_q};

  // Length of the current high pulse so far
  always_ff @(posedge clk) begin
    if (!rst_n_i || !clk_q) begin
      hi_run_q <= '0;
    end else begin
      hi_run_q <= hi_run_q + DIV_W'(1);
    end
  end

  // Cycles a buffered value has waited for its swap
  always_ff @(posedge clk) begin
    if (!rst_n_i || !pending_q || swap) begin
      pend_age_q <= '0;
    end else begin
      pend_age_q <= pend_age_q + (DIV_W+2)'(1);
    end
  end

  a_high_len: assert property (@(posedge clk) disable iff (!rst_n_i)
    clk_q |-> (hi_run_q < div_act_q));

  a_pend_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
    pending_q |-> (pend_age_q <= 2 * ((1 << DIV_W) - 1)));

endmodule

`default_nettype wire

//--- apb_pkg.sv
// APB bus types and the register map of the clock and reset generator.
// Requests and responses travel as one packed struct each.

`default_nettype none

package apb_pkg;

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Register offsets
  localparam logic [APB_AW-1:0] REG_CTRL        = 8'h00;
  localparam logic [APB_AW-1:0] REG_DIV_PER     = 8'h04;
  localparam logic [APB_AW-1:0] REG_DIV_CLUSTER = 8'h08;
  localparam logic [APB_AW-1:0] REG_DIV_AUX     = 8'h0C;
  localparam logic [APB_AW-1:0] REG_STATUS      = 8'h10;
  localparam logic [APB_AW-1:0] REG_ID          = 8'h14;

endpackage

`default_nettype wire

//--- clk_rst_pkg.sv
// Shared parameters and types of the clock and reset generator.
// Covers dividers, their configuration and status, and the domain reset vector.
// Import with a wildcard in the module header where these names are used.

`default_nettype none

package clk_rst_pkg;

  localparam int NUM_DIV         = 3;   // Peripheral, cluster, auxiliary
  localparam int DIV_W           = 16;
  localparam int RST_SYNC_STAGES = 3;

  localparam logic [DIV_W-1:0] DIV_DEFAULT = 16'd4;    // Divide value out of reset
  localparam logic [31:0]      ID_VALUE    = 32'hC1C0_0100;

  // Position of each divider in the configuration and status arrays
  typedef enum logic [1:0] {
    DIV_PER     = 2'd0,
    DIV_CLUSTER = 2'd1,
    DIV_AUX     = 2'd2
  } div_idx_e;

  // Divider configuration whose strobe is high for one cycle per write
  typedef struct packed {
    logic [DIV_W-1:0] value;
    logic             update;
  } div_cfg_t;

  typedef struct packed {
    logic pending;   // New value buffered but not yet in use
  } div_stat_t;

  // Active-low domain resets with glob in bit 0
  typedef struct packed {
    logic cluster;
    logic per;
    logic soc;
    logic glob;
  } rst_vec_t;

endpackage

`default_nettype wire
